/* mania_vectors.txt */
// song selection, then per image a byte count and its bytes (beatmap, timing)
// then 4 section sizes, 4 section bases, song length and the song bytes
07
1b
00 00 02 0a 0b 0c 1d 1e 1f
00 00 01 2a 2b 2c 00 00 01
3a 3b 3c 00 00 01 4a 4b 4c
0c
00 00 00 04 00 00 00 05 12 34 56 78
02 01 01 01
01 04 06 08
05
11 22 33 44 55

/* build.f */
mania_pkg.sv
bram_loader.sv
map_indexer.sv
audio_pacer.sv
boot_sequencer.sv
mania_core.sv
mania_core_assertions.sv
tb_mania_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the testbench with Verilator, pass only on the pass message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_mania_core -Mdir obj_dir -o sim_mania > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_mania > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* tb_mania_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the game core with BRAM models, a stalling
// prefetch source and a song source fed from the vector file
// checks start-up, tables and playback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mania_core
	import mania_pkg::*;
();
	logic CLK = 1'b0;
	logic RESET_L;
	logic [BYTE_W-1:0] song_selection, pre_data_in, song_data_in;
	logic pre_data_ready, pre_transmit_finished, song_data_ready;
	db_word_t db_b_data_out, db_a_data_in, db_rd1;
	dt_word_t dt_b_data_out, dt_a_data_in, dt_rd1;
	sec_sel_t sec_sel;
	logic pre_request_data, pre_restart, song_restart, song_request_data;
	logic [BYTE_W-1:0] pre_init_index, pre_init_aux_info, song_init_index, MAIN_AUDIO_OUT;
	logic [DB_ADDR_W-1:0] db_a_addr, db_b_addr, sec_size, sec_base;
	logic [DT_ADDR_W-1:0] dt_a_addr, dt_b_addr;
	logic db_a_en_w, db_b_en, dt_a_en_w, dt_b_en, AUDIO_EN;

	db_word_t db_mem [0:(1<<DB_ADDR_W)-1];
	dt_word_t dt_mem [0:(1<<DT_ADDR_W)-1];
	logic [31:0] vec [0:127];
	logic [7:0] img_byte [0:1][0:63];
	logic [7:0] song_byte [0:63];
	int img_len [0:1];
	int exp_size [0:3];
	int exp_base [0:3];
	int song_len;
	int seed;
	longint cycle = 0;
	longint cycle_limit;
	int err_per_test [1:6];
	int err_total = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int boot_test;

	logic pending, img;
	int stall, pos, restart_cnt, song_restart_cnt;
	int song_idx, audio_cnt;
	logic audio_chk;
	logic [7:0] audio_exp;
	logic audio_prev, rose, fell;
	longint rise_cycle, last_req_cycle;
	int req_count;

	mania_core dut0 (.*);

	always #20 CLK = ~CLK;

	task automatic check_value(input int test_id, input longint actual,
		input longint expected, input string what);
		if (actual != expected) begin
			$display("[FAIL] time %0t: %s: got %0h, expected %0h", $time, what, actual,
				expected);
			err_per_test[test_id]++;
			err_total++;
		end
	endtask

	task automatic finish_test(input int test_id, input string name);
		tests_run++;
		if (err_per_test[test_id] != 0)
			tests_failed++;
		$display("test %0d %s: %0d mismatches", test_id, name, err_per_test[test_id]);
	endtask

	task automatic wait_audio_start();
		while (!rose)
			@(posedge CLK);
	endtask

	// run limit against a stuck handshake
	always @(posedge CLK) begin
		cycle <= cycle + 1;
		if (cycle > cycle_limit) begin
			$display("timeout: the core did not finish start-up or playback in %0d cycles",
				cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(posedge CLK) begin
		if (db_a_en_w)
			db_mem[db_a_addr] <= db_a_data_in;
		if (dt_a_en_w)
			dt_mem[dt_a_addr] <= dt_a_data_in;
		if (db_b_en)
			db_rd1 <= db_mem[db_b_addr];
		if (dt_b_en)
			dt_rd1 <= dt_mem[dt_b_addr];
		db_b_data_out <= db_rd1;   // two cycle read
		dt_b_data_out <= dt_rd1;
	end

	// prefetch source with a random stall per request
	always @(posedge CLK) begin
		pre_data_ready <= 1'b0;
		pre_transmit_finished <= 1'b0;
		if (!RESET_L) begin
			pending <= 1'b0;
			restart_cnt <= 0;
			song_restart_cnt <= 0;
		end else begin
			if (pre_restart) begin
				check_value(boot_test, pre_init_index, song_selection, "pre_init_index");
				check_value(boot_test, pre_init_aux_info,
					(restart_cnt == 0) ? AUX_BEATMAP : AUX_TIMING, "pre_init_aux_info");
				img <= (pre_init_aux_info == AUX_TIMING);
				pos <= 0;
				restart_cnt <= restart_cnt + 1;
			end
			if (song_restart) begin
				check_value(boot_test, song_init_index, song_selection, "song_init_index");
				song_restart_cnt <= song_restart_cnt + 1;
			end
			if (pre_request_data) begin
				pending <= 1'b1;
				stall <= 1 + ($unsigned($random(seed)) % 5);
			end else if (pending) begin
				if (stall > 1) begin
					stall <= stall - 1;
				end else begin
					pending <= 1'b0;
					if (pos < img_len[img]) begin
						pre_data_in <= img_byte[img][pos];
						pre_data_ready <= 1'b1;
						pos <= pos + 1;
					end else begin
						pre_transmit_finished <= 1'b1;   // image exhausted
					end
				end
			end
		end
	end

	// song source with the output checked two edges after each strobe
	always @(posedge CLK) begin
		song_data_ready <= 1'b0;
		if (!RESET_L) begin
			song_idx <= 0;
			audio_cnt <= 0;
			audio_chk <= 1'b0;
		end else begin
			if (song_request_data && song_idx < song_len) begin
				song_data_in <= song_byte[song_idx];
				song_data_ready <= 1'b1;
				song_idx <= song_idx + 1;
			end
			audio_chk <= song_data_ready;
			audio_exp <= song_data_in;
			if (audio_chk) begin
				check_value(5, MAIN_AUDIO_OUT, audio_exp, "MAIN_AUDIO_OUT");
				audio_cnt <= audio_cnt + 1;
			end
		end
	end

	always @(posedge CLK) begin
		if (!RESET_L) begin
			audio_prev <= 1'b0;
			rose <= 1'b0;
			fell <= 1'b0;
			req_count <= 0;
		end else begin
			audio_prev <= AUDIO_EN;
			if (AUDIO_EN && !audio_prev) begin
				rise_cycle <= cycle;
				rose <= 1'b1;
			end
			if (!AUDIO_EN && audio_prev) begin
				fell <= 1'b1;
				check_value(4, cycle - last_req_cycle, 1, "AUDIO_EN fall after last request");
			end
			if (song_request_data) begin
				if (req_count == 0)
					check_value(4, cycle - rise_cycle, (PLAY_DELAY + 1) * SAMPLE_PERIOD,
						"first song request delay");
				else
					check_value(4, cycle - last_req_cycle, SAMPLE_PERIOD, "request spacing");
				last_req_cycle <= cycle;
				req_count <= req_count + 1;
			end
		end
	end

	initial begin
		int p;
		int i;
		longint per_boot;
		db_word_t db_exp;
		dt_word_t dt_exp;
		seed = 32'ha2531919;
		$readmemh("mania_vectors.txt", vec);
		song_selection = vec[0][7:0];
		p = 1;
		for (int k = 0; k < 2; k++) begin
			img_len[k] = vec[p];
			p++;
			for (i = 0; i < img_len[k]; i++)
				img_byte[k][i] = vec[p + i][7:0];
			p = p + img_len[k];
		end
		for (i = 0; i < 4; i++) begin
			exp_size[i] = vec[p + i];
			exp_base[i] = vec[p + 4 + i];
		end
		song_len = vec[p + 8];
		for (i = 0; i < song_len; i++)
			song_byte[i] = vec[p + 9 + i][7:0];
		// up to seven cycles per byte and three start-ups per run
		per_boot = (img_len[0] + img_len[1]) * 7 + 6 * READ_SLOTS
			+ (PLAY_DELAY + song_len + 2) * SAMPLE_PERIOD;
		cycle_limit = 2 * per_boot * 3;
		for (i = 1; i <= 6; i++)
			err_per_test[i] = 0;
		RESET_L = 1'b0;
		pre_data_in = '0;
		pre_data_ready = 1'b0;
		pre_transmit_finished = 1'b0;
		song_data_in = '0;
		song_data_ready = 1'b0;
		sec_sel = '0;
		db_rd1 = '0;
		dt_rd1 = '0;
		db_b_data_out = '0;
		dt_b_data_out = '0;
		boot_test = 1;
		repeat (2) @(posedge CLK);
		RESET_L <= 1'b1;

		wait_audio_start();
		check_value(1, restart_cnt, 2, "stream restarts");
		check_value(1, song_restart_cnt, 1, "song restarts");
		finish_test(1, "stream setup");

		for (i = 0; i < img_len[0] / 3; i++) begin
			db_exp = {img_byte[0][3*i], img_byte[0][3*i+1], img_byte[0][3*i+2]};
			check_value(2, db_mem[i], db_exp, "beatmap BRAM word");
		end
		for (i = 0; i < img_len[1] / 4; i++) begin
			dt_exp = {img_byte[1][4*i], img_byte[1][4*i+1], img_byte[1][4*i+2],
				img_byte[1][4*i+3]};
			check_value(2, dt_mem[i], dt_exp, "timing BRAM word");
		end
		finish_test(2, "image load");

		for (i = 0; i < 4; i++) begin
			sec_sel <= sec_sel_t'(i);
			@(posedge CLK);
			check_value(3, sec_size, exp_size[i], "sec_size");
			check_value(3, sec_base, exp_base[i], "sec_base");
			if (i == 0)
				check_value(3, sec_base, 1, "base of section 0");
			else
				check_value(3, sec_base, exp_base[i-1] + exp_size[i-1] + 1, "base rule");
		end
		finish_test(3, "section table");

		while (!fell)
			@(posedge CLK);
		repeat (3) @(posedge CLK);
		check_value(4, req_count, song_len, "song request count");
		finish_test(4, "playback pacing");
		check_value(5, audio_cnt, song_len, "audio bytes seen");
		finish_test(5, "audio data");

		// second start-up with a reset once playback has begun
		boot_test = 6;
		RESET_L <= 1'b0;
		repeat (2) @(posedge CLK);
		RESET_L <= 1'b1;
		wait_audio_start();
		while (req_count == 0)
			@(posedge CLK);
		RESET_L <= 1'b0;
		repeat (2) @(posedge CLK);
		check_value(6, {pre_request_data, pre_restart, song_restart, song_request_data},
			0, "stream outputs in reset");
		check_value(6, {db_a_en_w, dt_a_en_w, db_b_en, dt_b_en}, 0, "BRAM enables in reset");
		check_value(6, AUDIO_EN, 0, "AUDIO_EN in reset");
		check_value(6, MAIN_AUDIO_OUT, 0, "MAIN_AUDIO_OUT in reset");
		RESET_L <= 1'b1;
		wait_audio_start();
		check_value(6, restart_cnt, 2, "stream restarts after reset");
		check_value(6, song_restart_cnt, 1, "song restarts after reset");
		finish_test(6, "reset");

		$display("tests: %0d run, %0d failed, %0d mismatches", tests_run, tests_failed,
			err_total);
		if (err_total == 0 && tests_failed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* mania_core_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and write enable checks on the game core
// bound to every mania_core instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mania_core_assertions (
	input  logic CLK,
	input  logic RESET_L,
	input  logic pre_request_data,
	input  logic pre_data_ready,
	input  logic pre_transmit_finished,
	input  logic song_request_data,
	input  logic AUDIO_EN,
	input  logic db_ld_a_wen,
	input  logic dt_ld_a_wen
);
	logic waiting;    // a stream request is still unanswered

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			waiting <= 1'b0;
		else if (pre_request_data)
			waiting <= 1'b1;
		else if (pre_data_ready || pre_transmit_finished)
			waiting <= 1'b0;
	end

	a_one_request: assert property (@(posedge CLK) disable iff (!RESET_L)
		!(waiting && pre_request_data))
		else $error("second stream request before the answer");

	a_request_in_play: assert property (@(posedge CLK) disable iff (!RESET_L)
		song_request_data |-> AUDIO_EN)
		else $error("song request while audio is disabled");

	// loader side enables, ahead of the port mux
	a_one_writer: assert property (@(posedge CLK) disable iff (!RESET_L)
		!(db_ld_a_wen && dt_ld_a_wen))
		else $error("both BRAM loaders write in the same cycle");

endmodule

bind mania_core mania_core_assertions chk0 (
	.CLK(CLK), .RESET_L(RESET_L),
	.pre_request_data(pre_request_data), .pre_data_ready(pre_data_ready),
	.pre_transmit_finished(pre_transmit_finished),
	.song_request_data(song_request_data), .AUDIO_EN(AUDIO_EN),
	.db_ld_a_wen(db_ld_a_wen), .dt_ld_a_wen(dt_ld_a_wen)
);

`default_nettype wire

/* mania_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the rhythm game start-up and playback core
// connects both BRAM loaders, the table indexer, the audio
// pacer and the start-up FSM to the stream and BRAM pins
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mania_core
	import mania_pkg::*;
(
	input  logic CLK,
	input  logic RESET_L,
	input  logic [BYTE_W-1:0] song_selection,
	input  logic [BYTE_W-1:0] pre_data_in,
	input  logic pre_data_ready,
	input  logic pre_transmit_finished,
	input  logic [BYTE_W-1:0] song_data_in,
	input  logic song_data_ready,
	input  db_word_t db_b_data_out,
	input  dt_word_t dt_b_data_out,
	input  sec_sel_t sec_sel,
	output logic pre_request_data,
	output logic pre_restart,
	output logic [BYTE_W-1:0] pre_init_index,
	output logic [BYTE_W-1:0] pre_init_aux_info,
	output logic song_restart,
	output logic [BYTE_W-1:0] song_init_index,
	output logic song_request_data,
	output logic [DB_ADDR_W-1:0] db_a_addr,
	output db_word_t db_a_data_in,
	output logic db_a_en_w,
	output logic [DB_ADDR_W-1:0] db_b_addr,
	output logic db_b_en,
	output logic [DT_ADDR_W-1:0] dt_a_addr,
	output dt_word_t dt_a_data_in,
	output logic dt_a_en_w,
	output logic [DT_ADDR_W-1:0] dt_b_addr,
	output logic dt_b_en,
	output logic [DB_ADDR_W-1:0] sec_size,
	output logic [DB_ADDR_W-1:0] sec_base,
	output logic [BYTE_W-1:0] MAIN_AUDIO_OUT,
	output logic AUDIO_EN
);
	logic db_loader_start, db_loader_done, db_ld_request_data, db_ld_restart;
	logic [BYTE_W-1:0] db_ld_init_index, db_ld_init_aux_info;
	logic [DB_ADDR_W-1:0] db_ld_a_addr;
	db_word_t db_ld_a_data;
	logic db_ld_a_wen;
	logic dt_loader_start, dt_loader_done, dt_ld_request_data, dt_ld_restart;
	logic [BYTE_W-1:0] dt_ld_init_index, dt_ld_init_aux_info;
	logic [DT_ADDR_W-1:0] dt_ld_a_addr;
	dt_word_t dt_ld_a_data;
	logic dt_ld_a_wen;
	logic index_start, index_done, play_start;
	logic [DB_ADDR_W-1:0] idx_db_b_addr;
	logic idx_db_b_en;
	logic [DT_ADDR_W-1:0] idx_dt_b_addr;
	logic idx_dt_b_en;
	logic [SONG_LEN_W-1:0] song_length;

	assign song_init_index = song_selection;

	bram_loader #(.word_t(db_word_t), .addr_w(DB_ADDR_W), .aux_code(AUX_BEATMAP)) db_loader (
		.CLK(CLK), .RESET_L(RESET_L), .start(db_loader_start),
		.song_selection(song_selection), .pre_data_in(pre_data_in),
		.pre_data_ready(pre_data_ready), .pre_transmit_finished(pre_transmit_finished),
		.done(db_loader_done), .pre_request_data(db_ld_request_data),
		.pre_restart(db_ld_restart), .pre_init_index(db_ld_init_index),
		.pre_init_aux_info(db_ld_init_aux_info),
		.a_addr(db_ld_a_addr), .a_data(db_ld_a_data), .a_wen(db_ld_a_wen)
	);

	bram_loader #(.word_t(dt_word_t), .addr_w(DT_ADDR_W), .aux_code(AUX_TIMING)) dt_loader (
		.CLK(CLK), .RESET_L(RESET_L), .start(dt_loader_start),
		.song_selection(song_selection), .pre_data_in(pre_data_in),
		.pre_data_ready(pre_data_ready), .pre_transmit_finished(pre_transmit_finished),
		.done(dt_loader_done), .pre_request_data(dt_ld_request_data),
		.pre_restart(dt_ld_restart), .pre_init_index(dt_ld_init_index),
		.pre_init_aux_info(dt_ld_init_aux_info),
		.a_addr(dt_ld_a_addr), .a_data(dt_ld_a_data), .a_wen(dt_ld_a_wen)
	);

	map_indexer map_index0 (
		.CLK(CLK), .RESET_L(RESET_L), .start(index_start),
		.db_b_data(db_b_data_out), .dt_b_data(dt_b_data_out), .sec_sel(sec_sel),
		.done(index_done),
		.db_b_addr(idx_db_b_addr), .db_b_en(idx_db_b_en),
		.dt_b_addr(idx_dt_b_addr), .dt_b_en(idx_dt_b_en),
		.sec_size(sec_size), .sec_base(sec_base),
		.song_length(song_length),
		.note_count()   // kept inside the indexer, no pin
	);

	audio_pacer pacer0 (
		.CLK(CLK), .RESET_L(RESET_L), .start(play_start),
		.song_length(song_length),
		.song_data_in(song_data_in), .song_data_ready(song_data_ready),
		.song_request_data(song_request_data),
		.MAIN_AUDIO_OUT(MAIN_AUDIO_OUT), .AUDIO_EN(AUDIO_EN)
	);

	// every sequencer port has a same-named net here
	boot_sequencer boot0 (.*);

endmodule

`default_nettype wire

/* boot_sequencer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// start-up FSM: song restart, beatmap load, timing load,
// table scan, playback. hands the prefetch stream and the
// BRAM ports to whichever worker owns the current state
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module boot_sequencer
	import mania_pkg::*;
(
	input  logic CLK,
	input  logic RESET_L,
	input  logic db_loader_done,
	input  logic dt_loader_done,
	input  logic index_done,
	input  logic db_ld_request_data,
	input  logic db_ld_restart,
	input  logic [BYTE_W-1:0] db_ld_init_index,
	input  logic [BYTE_W-1:0] db_ld_init_aux_info,
	input  logic dt_ld_request_data,
	input  logic dt_ld_restart,
	input  logic [BYTE_W-1:0] dt_ld_init_index,
	input  logic [BYTE_W-1:0] dt_ld_init_aux_info,
	input  logic [DB_ADDR_W-1:0] db_ld_a_addr,
	input  db_word_t db_ld_a_data,
	input  logic db_ld_a_wen,
	input  logic [DT_ADDR_W-1:0] dt_ld_a_addr,
	input  dt_word_t dt_ld_a_data,
	input  logic dt_ld_a_wen,
	input  logic [DB_ADDR_W-1:0] idx_db_b_addr,
	input  logic idx_db_b_en,
	input  logic [DT_ADDR_W-1:0] idx_dt_b_addr,
	input  logic idx_dt_b_en,
	output logic song_restart,
	output logic db_loader_start,
	output logic dt_loader_start,
	output logic index_start,
	output logic play_start,
	output logic pre_request_data,
	output logic pre_restart,
	output logic [BYTE_W-1:0] pre_init_index,
	output logic [BYTE_W-1:0] pre_init_aux_info,
	output logic [DB_ADDR_W-1:0] db_a_addr,
	output db_word_t db_a_data_in,
	output logic db_a_en_w,
	output logic [DT_ADDR_W-1:0] dt_a_addr,
	output dt_word_t dt_a_data_in,
	output logic dt_a_en_w,
	output logic [DB_ADDR_W-1:0] db_b_addr,
	output logic db_b_en,
	output logic [DT_ADDR_W-1:0] dt_b_addr,
	output logic dt_b_en
);
	boot_state_t state;
	boot_state_t next_state;
	boot_state_t last_state;
	logic entered;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= s_idle;
			last_state <= s_idle;
		end else begin
			state <= next_state;
			last_state <= state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_idle:         next_state = s_song_restart;
			s_song_restart: next_state = s_load_db;
			s_load_db:
				if (db_loader_done)
					next_state = s_load_dt;
			s_load_dt:
				if (dt_loader_done)
					next_state = s_scan;
			s_scan:
				if (index_done)
					next_state = s_play;
			s_play:         next_state = s_play;   // held until reset
			default:        next_state = s_idle;
		endcase
	end

	// one start pulse on the first cycle of each worker state
	assign entered = state != last_state;
	assign song_restart = state == s_song_restart;
	assign db_loader_start = entered && state == s_load_db;
	assign dt_loader_start = entered && state == s_load_dt;
	assign index_start = entered && state == s_scan;
	assign play_start = entered && state == s_play;

	always_comb begin
		pre_request_data = 1'b0;
		pre_restart = 1'b0;
		pre_init_index = '0;
		pre_init_aux_info = '0;
		db_a_addr = '0;
		db_a_data_in = '0;
		db_a_en_w = 1'b0;
		dt_a_addr = '0;
		dt_a_data_in = '0;
		dt_a_en_w = 1'b0;
		db_b_addr = '0;
		db_b_en = 1'b0;
		dt_b_addr = '0;
		dt_b_en = 1'b0;
		case (state)
			s_load_db: begin
				pre_request_data = db_ld_request_data;
				pre_restart = db_ld_restart;
				pre_init_index = db_ld_init_index;
				pre_init_aux_info = db_ld_init_aux_info;
				db_a_addr = db_ld_a_addr;
				db_a_data_in = db_ld_a_data;
				db_a_en_w = db_ld_a_wen;
			end
			s_load_dt: begin
				pre_request_data = dt_ld_request_data;
				pre_restart = dt_ld_restart;
				pre_init_index = dt_ld_init_index;
				pre_init_aux_info = dt_ld_init_aux_info;
				dt_a_addr = dt_ld_a_addr;
				dt_a_data_in = dt_ld_a_data;
				dt_a_en_w = dt_ld_a_wen;
			end
			s_scan: begin
				db_b_addr = idx_db_b_addr;
				db_b_en = idx_db_b_en;
				dt_b_addr = idx_dt_b_addr;
				dt_b_en = idx_dt_b_en;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* audio_pacer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// audio playback pacing: sample tick divider, start delay,
// one song byte request per tick until the song is done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module audio_pacer
	import mania_pkg::*;
(
	input  logic CLK,
	input  logic RESET_L,
	input  logic start,
	input  logic [SONG_LEN_W-1:0] song_length,
	input  logic [BYTE_W-1:0] song_data_in,
	input  logic song_data_ready,
	output logic song_request_data,
	output logic [BYTE_W-1:0] MAIN_AUDIO_OUT,
	output logic AUDIO_EN
);
	localparam int DIV_W = $clog2(SAMPLE_PERIOD);
	localparam int DLY_W = $clog2(PLAY_DELAY + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [DLY_W-1:0] delay_cnt;
	logic [SONG_LEN_W-1:0] req_cnt;
	logic tick;
	logic delay_over;
	logic all_sent;
	logic req_fire;

	assign tick = AUDIO_EN && div_cnt == DIV_W'(SAMPLE_PERIOD - 1);
	assign delay_over = delay_cnt == DLY_W'(PLAY_DELAY);
	assign all_sent = req_cnt == song_length;
	assign req_fire = tick && delay_over && !all_sent;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			AUDIO_EN <= 1'b0;
			song_request_data <= 1'b0;
			div_cnt <= '0;
			delay_cnt <= '0;
			req_cnt <= '0;
		end else begin
			song_request_data <= req_fire;
			if (start) begin
				AUDIO_EN <= 1'b1;
				div_cnt <= '0;
				delay_cnt <= '0;
				req_cnt <= '0;
			end else if (AUDIO_EN) begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick && !delay_over)
					delay_cnt <= delay_cnt + 1'b1;   // silent samples
				if (req_fire)
					req_cnt <= req_cnt + 1'b1;
				// stops after the last request, an empty song stops at its first tick
				if ((song_request_data && all_sent) || (tick && delay_over && all_sent))
					AUDIO_EN <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			MAIN_AUDIO_OUT <= '0;
		else if (song_data_ready)
			MAIN_AUDIO_OUT <= song_data_in;
	end

endmodule

`default_nettype wire

/* map_indexer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// walks the beatmap section size table and the timing header
// over port B, four cycles per read, and keeps the section
// sizes and bases, the note count and the song length
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module map_indexer
	import mania_pkg::*;
(
	input  logic CLK,
	input  logic RESET_L,
	input  logic start,
	input  db_word_t db_b_data,
	input  dt_word_t dt_b_data,
	input  sec_sel_t sec_sel,
	output logic done,
	output logic [DB_ADDR_W-1:0] db_b_addr,
	output logic db_b_en,
	output logic [DT_ADDR_W-1:0] dt_b_addr,
	output logic dt_b_en,
	output logic [DB_ADDR_W-1:0] sec_size,
	output logic [DB_ADDR_W-1:0] sec_base,
	output logic [SONG_LEN_W-1:0] song_length,
	output logic [DT_ADDR_W-1:0] note_count
);
	localparam int SLOT_W = $clog2(READ_SLOTS);

	logic active;
	logic timing_phase;        // header reads after the size table
	sec_sel_t idx;
	sec_sel_t prev;
	logic [SLOT_W-1:0] slot;
	logic last_slot;
	logic [DB_ADDR_W-1:0] size_q [NUM_SECTIONS];
	logic [DB_ADDR_W-1:0] base_q [NUM_SECTIONS];

	assign prev = idx - 1'b1;
	assign last_slot = slot == SLOT_W'(READ_SLOTS - 1);

	// size word of a section sits just past the end of the one before
	assign db_b_addr = (idx == '0) ? '0 : base_q[prev] + size_q[prev];
	assign db_b_en = active && !timing_phase;
	assign dt_b_addr = DT_ADDR_W'(idx[0]);   // 0 note count, 1 song length
	assign dt_b_en = active && timing_phase;

	assign sec_size = size_q[sec_sel];
	assign sec_base = base_q[sec_sel];

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			active <= 1'b0;
			timing_phase <= 1'b0;
			idx <= '0;
			slot <= '0;
			done <= 1'b0;
		end else begin
			done <= active && timing_phase && idx[0] && last_slot;
			if (start) begin
				active <= 1'b1;
				timing_phase <= 1'b0;
				idx <= '0;
				slot <= '0;
			end else if (active) begin
				slot <= last_slot ? '0 : slot + 1'b1;
				if (last_slot) begin
					idx <= idx + 1'b1;
					if (!timing_phase && idx == sec_sel_t'(NUM_SECTIONS - 1)) begin
						timing_phase <= 1'b1;
						idx <= '0;
					end else if (timing_phase && idx[0]) begin
						active <= 1'b0;
						idx <= '0;
					end
				end
			end
		end
	end

	// read data settles by slot 2, taken in slot 3
	always_ff @(posedge CLK) begin
		if (active && last_slot) begin
			if (!timing_phase) begin
				size_q[idx] <= db_b_data[DB_ADDR_W-1:0];
				base_q[idx] <= (idx == '0) ? DB_ADDR_W'(1) : db_b_addr + 1'b1;
			end else if (idx[0]) begin
				song_length <= dt_b_data[SONG_LEN_W-1:0];
			end else begin
				note_count <= dt_b_data[DT_ADDR_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* bram_loader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fills one BRAM from the prefetch byte stream
// restarts the stream, fetches one byte per request, packs
// bytes msb first and writes each full word on port A
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bram_loader
	import mania_pkg::*;
#(
	parameter type word_t = db_word_t,
	parameter int addr_w = DB_ADDR_W,
	parameter logic [BYTE_W-1:0] aux_code = AUX_BEATMAP
) (
	input  logic CLK,
	input  logic RESET_L,
	input  logic start,
	input  logic [BYTE_W-1:0] song_selection,
	input  logic [BYTE_W-1:0] pre_data_in,
	input  logic pre_data_ready,
	input  logic pre_transmit_finished,
	output logic done,
	output logic pre_request_data,
	output logic pre_restart,
	output logic [BYTE_W-1:0] pre_init_index,
	output logic [BYTE_W-1:0] pre_init_aux_info,
	output logic [addr_w-1:0] a_addr,
	output word_t a_data,
	output logic a_wen
);
	localparam int WORD_W = $bits(word_t);
	localparam int BYTES = WORD_W / BYTE_W;
	localparam int CNT_W = $clog2(BYTES + 1);

	logic busy;
	logic [CNT_W-1:0] byte_cnt;
	logic [addr_w-1:0] wr_addr;
	word_t word_q;

	assign pre_init_index = song_selection;
	assign pre_init_aux_info = aux_code;
	assign a_addr = wr_addr;
	assign a_data = word_q;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			busy <= 1'b0;
			done <= 1'b0;
			pre_restart <= 1'b0;
			pre_request_data <= 1'b0;
			byte_cnt <= '0;
			wr_addr <= '0;
			a_wen <= 1'b0;
		end else begin
			pre_restart <= start;
			// first request right after restart, then one per answered byte
			pre_request_data <= pre_restart || (busy && pre_data_ready);
			done <= busy && pre_transmit_finished;
			a_wen <= 1'b0;
			if (a_wen)
				wr_addr <= wr_addr + 1'b1;
			if (start) begin
				busy <= 1'b1;
				byte_cnt <= '0;
				wr_addr <= '0;
			end else if (busy && pre_transmit_finished) begin
				busy <= 1'b0;
			end else if (busy && pre_data_ready) begin
				if (byte_cnt == CNT_W'(BYTES - 1)) begin
					byte_cnt <= '0;
					a_wen <= 1'b1;     // word complete
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (busy && pre_data_ready)
			word_q <= {word_q[WORD_W-BYTE_W-1:0], pre_data_in};
	end

endmodule

`default_nettype wire

/* mania_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, BRAM word shapes, timing constants and the
// start-up state type of the rhythm game core
// imported by wildcard in every RTL module header
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mania_pkg;

	localparam int BYTE_W = 8;        // stream byte and song byte
	localparam int DB_ADDR_W = 13;
	localparam int DT_ADDR_W = 12;

	typedef logic [23:0] db_word_t;   // beatmap BRAM word
	typedef logic [31:0] dt_word_t;   // timing BRAM word

	localparam int NUM_SECTIONS = 4;
	typedef logic [1:0] sec_sel_t;

	localparam int SONG_LEN_W = 20;

	// aux info codes sent with a stream restart
	localparam logic [BYTE_W-1:0] AUX_BEATMAP = BYTE_W'(0);
	localparam logic [BYTE_W-1:0] AUX_TIMING = BYTE_W'(3);

	// scaled down for simulation, hardware uses 2267 and 66150
	localparam int SAMPLE_PERIOD = 16;
	localparam int PLAY_DELAY = 6;

	localparam int READ_SLOTS = 4;    // cycles per table read

	typedef enum logic [2:0] {
		s_idle,
		s_song_restart,
		s_load_db,
		s_load_dt,
		s_scan,
		s_play
	} boot_state_t;

endpackage

`default_nettype wire
